// ==== hdl/coreTypes_pkg.sv ====
package coreTypes_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Data word of the integer core
    localparam int WORD_WIDTH = 32;

    // Register number, 32 architectural registers
    localparam int REG_ADDR_WIDTH = 5;

    // ------------------------------
    // Opcodes and states
    // ------------------------------

    // Register-to-register ALU operations
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        // Signed compare, result is 1 or 0
        SLT
    } aluOp_e;

    // Issue FSM
    // PAIR issues whole pairs, SECOND finishes a split pair
    typedef enum logic {
        PAIR,
        SECOND
    } issueState_e;

    // ------------------------------
    // Bundles
    // ------------------------------

    // One ALU instruction, 18 bits
    typedef struct packed {
        aluOp_e                    op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
    } inst_t;

    // Instruction pair in program order
    // slot0 is earlier, slot1 is later
    typedef struct packed {
        inst_t slot0;
        inst_t slot1;
    } instPair_t;

    // Result leaving writeback, also a register file write port
    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [WORD_WIDTH-1:0]     data;
    } retire_t;

endpackage

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                                          clk,
    input  logic                                          rst,
    // Read ports
    // 0 and 1 for slot0 rs1/rs2, 2 and 3 for slot1 rs1/rs2
    input  logic [3:0][coreTypes_pkg::REG_ADDR_WIDTH-1:0] readNum_i,
    output logic [3:0][coreTypes_pkg::WORD_WIDTH-1:0]     readData_o,
    // Write ports, write1 is the later slot
    input  coreTypes_pkg::retire_t                        write0_i,
    input  coreTypes_pkg::retire_t                        write1_i
);

    import coreTypes_pkg::*;

    // Register 0 has no storage
    logic [WORD_WIDTH-1:0] regs [31:1];

    // Forward hits per read port and write port
    logic [3:0] hit0;
    logic [3:0] hit1;

    // Write enables with register 0 dropped
    logic wrEn0;
    logic wrEn1;

    assign wrEn0 = write0_i.valid && (write0_i.rd != '0);
    assign wrEn1 = write1_i.valid && (write1_i.rd != '0);

    // ------------------------------
    // Read side with forwarding
    // ------------------------------

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            hit0[p] = wrEn0 && (write0_i.rd == readNum_i[p]);
            hit1[p] = wrEn1 && (write1_i.rd == readNum_i[p]);
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (readNum_i[p] == '0) begin
                // Hardwired zero
                readData_o[p] = '0;
            end else if (hit1[p]) begin
                // Later slot first, same as the stored result
                readData_o[p] = write1_i.data;
            end else if (hit0[p]) begin
                readData_o[p] = write0_i.data;
            end else begin
                readData_o[p] = regs[readNum_i[p]];
            end
        end
    end

    // ------------------------------
    // Write side
    // ------------------------------

    // Port 1 is written last, so it wins on an equal destination
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrEn0) begin
                regs[write0_i.rd] <= write0_i.data;
            end
            if (wrEn1) begin
                regs[write1_i.rd] <= write1_i.data;
            end
        end
    end

endmodule

// ==== hdl/intAlu.sv ====
`timescale 1ns/1ps

module intAlu (
    input  coreTypes_pkg::aluOp_e                  op_i,
    input  logic [coreTypes_pkg::WORD_WIDTH-1:0]   a_i,
    input  logic [coreTypes_pkg::WORD_WIDTH-1:0]   b_i,
    output logic [coreTypes_pkg::WORD_WIDTH-1:0]   result_o
);

    import coreTypes_pkg::*;

    // Signed compare feeding SLT
    logic lessThan;

    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ADD: begin
                result_o = a_i + b_i;
            end
            // Two's-complement subtract
            SUB: begin
                result_o = a_i - b_i;
            end
            AND: begin
                result_o = a_i & b_i;
            end
            OR: begin
                result_o = a_i | b_i;
            end
            XOR: begin
                result_o = a_i ^ b_i;
            end
            // Zero-extended flag
            SLT: begin
                result_o = {{(WORD_WIDTH-1){1'b0}}, lessThan};
            end
            // Unused encodings give zero
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/issueCtrl.sv ====
`timescale 1ns/1ps

module issueCtrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issueValid_i,
    input  coreTypes_pkg::instPair_t pair_i,
    output logic                     ready_o,
    output logic                     exec0_o,
    output logic                     exec1_o,
    output logic                     split_o
);

    import coreTypes_pkg::*;

    issueState_e stateQ;
    issueState_e nextState;

    // Later slot reads the earlier slot's destination
    logic hazard;

    // Register 0 never creates a dependency
    assign hazard = (pair_i.slot0.rd != '0) &&
                    ((pair_i.slot0.rd == pair_i.slot1.rs1) ||
                     (pair_i.slot0.rd == pair_i.slot1.rs2));

    // ------------------------------
    // Issue decision
    // ------------------------------

    always_comb begin
        nextState = stateQ;
        exec0_o   = 1'b0;
        exec1_o   = 1'b0;
        split_o   = 1'b0;
        ready_o   = 1'b1;
        case (stateQ)
            PAIR: begin
                if (issueValid_i) begin
                    exec0_o = 1'b1;
                    if (hazard) begin
                        // Hold the pair, slot1 goes next cycle
                        split_o   = 1'b1;
                        ready_o   = 1'b0;
                        nextState = SECOND;
                    end else begin
                        exec1_o = 1'b1;
                    end
                end
            end
            SECOND: begin
                // Slot0 result now sits in writeback, picked up by forwarding
                exec1_o   = issueValid_i;
                nextState = PAIR;
            end
            default: begin
                nextState = PAIR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            stateQ <= PAIR;
        end else begin
            stateQ <= nextState;
        end
    end

endmodule

// ==== hdl/retireCounter.sv ====
`timescale 1ns/1ps

module retireCounter #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   retire0Valid_i,
    input  logic                   retire1Valid_i,
    input  logic                   split_i,
    output logic [COUNT_WIDTH-1:0] retiredCount_o,
    output logic [COUNT_WIDTH-1:0] splitCount_o
);

    // Retires this cycle, zero to two
    logic [1:0] retireInc;

    assign retireInc = {1'b0, retire0Valid_i} + {1'b0, retire1Valid_i};

    // Both counters wrap at their width
    always_ff @(posedge clk) begin
        if (!rst) begin
            retiredCount_o <= '0;
            splitCount_o   <= '0;
        end else begin
            retiredCount_o <= retiredCount_o + COUNT_WIDTH'(retireInc);
            if (split_i) begin
                splitCount_o <= splitCount_o + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/execStage.sv ====
`timescale 1ns/1ps

module execStage (
    input  logic                                          clk,
    input  logic                                          rst,
    // Issue side
    input  logic                                          accept_i,
    input  coreTypes_pkg::instPair_t                      pair_i,
    input  logic                                          exec0_i,
    input  logic                                          exec1_i,
    output logic                                          issueValid_o,
    output coreTypes_pkg::instPair_t                      issuePair_o,
    // Register file side
    output logic [3:0][coreTypes_pkg::REG_ADDR_WIDTH-1:0] readNum_o,
    input  logic [3:0][coreTypes_pkg::WORD_WIDTH-1:0]     readData_i,
    // Writeback register
    output coreTypes_pkg::retire_t                        retire0_o,
    output coreTypes_pkg::retire_t                        retire1_o
);

    import coreTypes_pkg::*;

    // Issue register
    logic      issueValidQ;
    instPair_t issuePairQ;

    // Slots indexed 0 and 1
    inst_t [1:0]                 slot;
    logic  [1:0]                 slotEnable;
    logic  [1:0][WORD_WIDTH-1:0] aluResult;

    // Writeback register
    logic [1:0]                     wbValid;
    logic [1:0][REG_ADDR_WIDTH-1:0] wbRd;
    logic [1:0][WORD_WIDTH-1:0]     wbData;

    // ------------------------------
    // Issue register
    // ------------------------------

    // Pair is done once slot1 executes
    always_ff @(posedge clk) begin
        if (!rst) begin
            issueValidQ <= 1'b0;
        end else if (accept_i) begin
            issueValidQ <= 1'b1;
        end else if (exec1_i) begin
            issueValidQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            issuePairQ <= pair_i;
        end
    end

    assign issueValid_o = issueValidQ;
    assign issuePair_o  = issuePairQ;

    // ------------------------------
    // Operands and ALUs
    // ------------------------------

    assign slot       = {issuePairQ.slot1, issuePairQ.slot0};
    assign slotEnable = {exec1_i, exec0_i};

    // Even port rs1, odd port rs2
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            readNum_o[2*s]   = slot[s].rs1;
            readNum_o[2*s+1] = slot[s].rs2;
        end
    end

    intAlu alu0 (
        .op_i     (slot[0].op),
        .a_i      (readData_i[0]),
        .b_i      (readData_i[1]),
        .result_o (aluResult[0])
    );

    intAlu alu1 (
        .op_i     (slot[1].op),
        .a_i      (readData_i[2]),
        .b_i      (readData_i[3]),
        .result_o (aluResult[1])
    );

    // ------------------------------
    // Writeback register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            wbValid <= '0;
        end else begin
            wbValid <= slotEnable;
        end
    end

    // Payload only moves for an enabled slot
    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (slotEnable[s]) begin
                wbRd[s]   <= slot[s].rd;
                wbData[s] <= aluResult[s];
            end
        end
    end

    assign retire0_o = '{valid: wbValid[0], rd: wbRd[0], data: wbData[0]};
    assign retire1_o = '{valid: wbValid[1], rd: wbRd[1], data: wbData[1]};

endmodule

// ==== hdl/dualIssueCore.sv ====
`timescale 1ns/1ps

module dualIssueCore #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pairValid_i,
    input  coreTypes_pkg::instPair_t pair_i,
    output logic                     ready_o,
    output coreTypes_pkg::retire_t   retire0_o,
    output coreTypes_pkg::retire_t   retire1_o,
    output logic [COUNT_WIDTH-1:0]   retiredCount_o,
    output logic [COUNT_WIDTH-1:0]   splitCount_o
);

    import coreTypes_pkg::*;

    // Handshake and issue
    logic      ready;
    logic      accept;
    logic      issueValid;
    instPair_t issuePair;
    logic      exec0;
    logic      exec1;
    logic      split;

    // Register file reads
    logic [3:0][REG_ADDR_WIDTH-1:0] readNum;
    logic [3:0][WORD_WIDTH-1:0]     readData;

    // Plain strobe, taken whenever ready
    assign accept  = pairValid_i && ready;
    assign ready_o = ready;

    issueCtrl issueCtrl (
        .clk          (clk),
        .rst          (rst),
        .issueValid_i (issueValid),
        .pair_i       (issuePair),
        .ready_o      (ready),
        .exec0_o      (exec0),
        .exec1_o      (exec1),
        .split_o      (split)
    );

    execStage execStage (
        .clk          (clk),
        .rst          (rst),
        .accept_i     (accept),
        .pair_i       (pair_i),
        .exec0_i      (exec0),
        .exec1_i      (exec1),
        .issueValid_o (issueValid),
        .issuePair_o  (issuePair),
        .readNum_o    (readNum),
        .readData_i   (readData),
        .retire0_o    (retire0_o),
        .retire1_o    (retire1_o)
    );

    // Writeback results go straight to the write ports
    regFile regFile (
        .clk        (clk),
        .rst        (rst),
        .readNum_i  (readNum),
        .readData_o (readData),
        .write0_i   (retire0_o),
        .write1_i   (retire1_o)
    );

    retireCounter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) retireCounter (
        .clk            (clk),
        .rst            (rst),
        .retire0Valid_i (retire0_o.valid),
        .retire1Valid_i (retire1_o.valid),
        .split_i        (split),
        .retiredCount_o (retiredCount_o),
        .splitCount_o   (splitCount_o)
    );

endmodule

// ==== verif/dualIssueCore_chk.sv ====
`timescale 1ns/1ps

module dualIssueCore_chk #(
    parameter int COUNT_WIDTH = 16
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   ready_i,
    input logic                   retire0Valid_i,
    input logic                   retire1Valid_i,
    input logic [COUNT_WIDTH-1:0] retiredCount_i
);

    // Count of failed assertions
    int failCount = 0;

    // ------------------------------
    // Port properties
    // ------------------------------

    // Writeback empty right after reset
    resetClearsRetire: assert property (
        @(posedge clk) !rst |=> !(retire0Valid_i || retire1Valid_i)
    ) else begin
        $error("retire valid in the cycle after reset");
        failCount++;
    end

    // Split cycle retires slot0 alone
    splitRetiresSlot0: assert property (
        @(posedge clk) disable iff (!rst)
        !ready_i |=> (retire0Valid_i && !retire1Valid_i)
    ) else begin
        $error("retire1 valid after a split cycle without retire0 alone");
        failCount++;
    end

    // Count only grows
    countMonotonic: assert property (
        @(posedge clk) disable iff (!rst)
        retiredCount_i >= $past(retiredCount_i)
    ) else begin
        $error("retired count decreased");
        failCount++;
    end

endmodule

// ==== verif/dualIssueCore_tb.sv ====
`timescale 1ns/1ps

module dualIssueCore_tb;

    import coreTypes_pkg::*;

    localparam int COUNT_WIDTH    = 16;
    localparam int NUM_PAIRS      = 2000;
    // Worst pair is idle, accept and split cycle
    localparam int TIMEOUT_CYCLES = NUM_PAIRS * 3 + 50;

    // One expected retire, in program order
    typedef struct packed {
        logic                      slot;
        logic                      split;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [WORD_WIDTH-1:0]     data;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   pairValid;
    instPair_t              pair;
    logic                   ready;
    retire_t                retire0;
    retire_t                retire1;
    logic [COUNT_WIDTH-1:0] retiredCount;
    logic [COUNT_WIDTH-1:0] splitCount;

    // Reference model state
    logic [WORD_WIDTH-1:0] modelRegs [0:31];
    expect_t               expectQ [$];
    int                    hazardCount;
    int                    cycleCount = 0;
    integer                seed;

    dualIssueCore #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .pairValid_i    (pairValid),
        .pair_i         (pair),
        .ready_o        (ready),
        .retire0_o      (retire0),
        .retire1_o      (retire1),
        .retiredCount_o (retiredCount),
        .splitCount_o   (splitCount)
    );

    bind dualIssueCore dualIssueCore_chk #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) portChecks (
        .clk            (clk),
        .rst            (rst),
        .ready_i        (ready_o),
        .retire0Valid_i (retire0_o.valid),
        .retire1Valid_i (retire1_o.valid),
        .retiredCount_i (retiredCount_o)
    );

    // ------------------------------
    // Clock and timeout
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, pairs or retires stopped moving", cycleCount);
            abortRun();
        end
    end

    // ------------------------------
    // Reporting
    // ------------------------------

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            abortRun();
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [WORD_WIDTH-1:0] aluRef(input aluOp_e op,
                                                     input logic [WORD_WIDTH-1:0] a,
                                                     input logic [WORD_WIDTH-1:0] b);
        logic [WORD_WIDTH-1:0] res;
        logic                  less;
        // Signed order from sign bits, unsigned order on equal signs
        if (a[WORD_WIDTH-1] != b[WORD_WIDTH-1]) begin
            less = a[WORD_WIDTH-1];
        end else begin
            less = a < b;
        end
        case (op)
            ADD: res = a + b;
            SUB: res = a + ~b + 1'b1;
            AND: res = a & b;
            OR: res = a | b;
            XOR: res = a ^ b;
            SLT: res = less ? 1 : 0;
            default: res = '0;
        endcase
        return res;
    endfunction

    // Later slot reads earlier destination
    function automatic logic pairSplits(input instPair_t p);
        return (p.slot0.rd != 0) &&
               ((p.slot0.rd == p.slot1.rs1) || (p.slot0.rd == p.slot1.rs2));
    endfunction

    // Program order, slot1 sees slot0's write and wins on equal rd
    task automatic applyPair(input instPair_t p, input logic hazard);
        logic [WORD_WIDTH-1:0] res0;
        logic [WORD_WIDTH-1:0] res1;
        res0 = aluRef(p.slot0.op, modelRegs[p.slot0.rs1], modelRegs[p.slot0.rs2]);
        if (p.slot0.rd != 0) begin
            modelRegs[p.slot0.rd] = res0;
        end
        res1 = aluRef(p.slot1.op, modelRegs[p.slot1.rs1], modelRegs[p.slot1.rs2]);
        if (p.slot1.rd != 0) begin
            modelRegs[p.slot1.rd] = res1;
        end
        expectQ.push_back('{slot: 1'b0, split: hazard, rd: p.slot0.rd, data: res0});
        expectQ.push_back('{slot: 1'b1, split: hazard, rd: p.slot1.rd, data: res1});
        if (hazard) begin
            hazardCount++;
        end
    endtask

    // ------------------------------
    // Random stimulus
    // ------------------------------

    // Mostly registers 0 to 3, so hazards and forwarding are frequent
    function automatic logic [REG_ADDR_WIDTH-1:0] randomReg();
        logic [31:0]               r;
        logic [REG_ADDR_WIDTH-1:0] num;
        r = $random(seed);
        if (r[31:30] == 2'b00) begin
            num = r[REG_ADDR_WIDTH-1:0];
        end else begin
            num = REG_ADDR_WIDTH'(r[1:0]);
        end
        return num;
    endfunction

    function automatic inst_t randomInst();
        inst_t       inst;
        logic [31:0] opNum;
        opNum    = $random(seed);
        opNum    = opNum % 6;
        inst.op  = aluOp_e'(opNum[2:0]);
        inst.rd  = randomReg();
        inst.rs1 = randomReg();
        inst.rs2 = randomReg();
        return inst;
    endfunction

    // Starts and ends on a falling edge
    task automatic sendPair(input instPair_t p);
        logic hazard;
        hazard    = pairSplits(p);
        pairValid = 1'b1;
        pair      = p;
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        applyPair(p, hazard);
        @(negedge clk);
        pairValid = 1'b0;
        // Split holds ready low for exactly one cycle
        checkValue("ready after accept", !hazard, ready);
        if (hazard) begin
            @(negedge clk);
            checkValue("ready after split", 1'b1, ready);
        end
    endtask

    // ------------------------------
    // Retire monitor
    // ------------------------------

    task automatic checkRetire(input logic slot, input retire_t r, input logic otherValid);
        expect_t e;
        if (expectQ.size() == 0) begin
            $display("Slot %0d retired with no instruction outstanding", slot);
            abortRun();
        end else begin
            e = expectQ.pop_front();
            checkValue("retire slot", e.slot, slot);
            checkValue("retire rd", e.rd, r.rd);
            checkValue("retire data", e.data, r.data);
            // Whole pair retires together, split pair one slot at a time
            if (!slot) begin
                checkValue("slot1 beside slot0", !e.split, otherValid);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst && retire0.valid) begin
            checkRetire(1'b0, retire0, retire1.valid);
        end
        if (rst && retire1.valid) begin
            checkRetire(1'b1, retire1, retire0.valid);
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        logic [31:0] gap;
        seed        = 32'hc81e_6d79;
        rst         = 1'b0;
        pairValid   = 1'b0;
        pair        = '0;
        hazardCount = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Reset state
        checkValue("reset ready", 1'b1, ready);
        checkValue("reset retire0 valid", 1'b0, retire0.valid);
        checkValue("reset retire1 valid", 1'b0, retire1.valid);
        checkValue("reset retired count", 0, retiredCount);
        checkValue("reset split count", 0, splitCount);

        for (int n = 0; n < NUM_PAIRS; n++) begin
            gap = $random(seed);
            // Occasional idle cycle between pairs
            if (gap[1:0] == 2'b00) begin
                @(negedge clk);
            end
            sendPair('{slot0: randomInst(), slot1: randomInst()});
        end

        // Drain writeback, counters lag one edge
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        @(negedge clk);
        checkValue("retired count", 2 * NUM_PAIRS, retiredCount);
        checkValue("split count", hazardCount, splitCount);

        // Bound port properties
        if (DUT.portChecks.failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/coreTypes_pkg.sv
hdl/regFile.sv
hdl/intAlu.sv
hdl/issueCtrl.sv
hdl/retireCounter.sv
hdl/execStage.sv
hdl/dualIssueCore.sv
verif/dualIssueCore_chk.sv
verif/dualIssueCore_tb.sv
